// ==== project.f ====
+incdir+rtl
rtl/ooo_pkg.sv
rtl/dispatch_unit.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_writeback.sv
rtl/tomasulo_core.sv
test/tomasulo_core_tb.sv

// ==== Bender.yml ====
package:
  name: tomasulo_core

export_include_dirs:
  - rtl

sources:
  - rtl/ooo_pkg.sv
  - rtl/dispatch_unit.sv
  - rtl/reservation_station.sv
  - rtl/alu_unit.sv
  - rtl/mul_unit.sv
  - rtl/cdb_writeback.sv
  - rtl/tomasulo_core.sv
  - target: test
    files:
      - test/tomasulo_core_tb.sv

// ==== test/tomasulo_core_tb.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module tomasulo_core_tb;

    localparam int NUM_TAGS = 1 << `OOO_TAG_WIDTH;
    localparam int WAIT_LIMIT = 300;

    logic                clk;
    logic                rst;
    ooo_pkg::issue_req_t issue;
    logic                issue_ready;
    ooo_pkg::tag_t       issue_tag;
    ooo_pkg::cdb_t       cdb;

    // sequential register model and per-tag expectations
    ooo_pkg::data_t model [`OOO_NUM_REGS];
    ooo_pkg::data_t exp_data [NUM_TAGS];
    logic           exp_is_mul [NUM_TAGS];
    logic           pending [NUM_TAGS];
    int             outstanding;
    ooo_pkg::tag_t  last_tag;
    ooo_pkg::tag_t  exp_tag;
    ooo_pkg::tag_t  mul_order [$];
    logic           saw_stall;
    logic [31:0]    lcg_state;
    ooo_pkg::data_t preload_val;

    tomasulo_core u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_ready (issue_ready),
        .issue_tag   (issue_tag),
        .cdb         (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected value of one operation from the ISA rules
    function automatic ooo_pkg::data_t ref_result(logic is_mul, logic [2:0] op,
                                                  ooo_pkg::data_t a, ooo_pkg::data_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        if (is_mul) begin
            return op[0] ? prod[63:32] : prod[31:0];
        end
        case (ooo_pkg::alu_op_t'(op))
            ooo_pkg::alu_add: return a + b;
            ooo_pkg::alu_sub: return a - b;
            ooo_pkg::alu_and: return a & b;
            ooo_pkg::alu_or:  return a | b;
            ooo_pkg::alu_xor: return a ^ b;
            ooo_pkg::alu_sll: return a << b[4:0];
            ooo_pkg::alu_srl: return a >> b[4:0];
            default:          return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    task fail_now(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // stall until both stations have room and the next tag is retired
    task wait_slot();
        int cycles;
        cycles = 0;
        while (!issue_ready || pending[issue_tag]) begin
            if (!issue_ready) begin
                saw_stall = 1'b1;
            end
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for a free station slot and tag");
            end
        end
    endtask

    task drive(logic is_mul, logic [2:0] op, ooo_pkg::reg_idx_t rd, ooo_pkg::reg_idx_t rs1,
               ooo_pkg::reg_idx_t rs2, ooo_pkg::data_t a, ooo_pkg::data_t b);
        assert (issue_tag == exp_tag)
            else fail_now($sformatf("mismatch at %0t: issue_tag %0d expected %0d",
                                    $time, issue_tag, exp_tag));
        issue.valid = 1'b1;
        issue.unit = is_mul ? ooo_pkg::unit_mul : ooo_pkg::unit_alu;
        issue.op = op;
        issue.rd = rd;
        issue.rs1 = rs1;
        issue.rs2 = rs2;
        last_tag = issue_tag;
        exp_data[issue_tag] = ref_result(is_mul, op, a, b);
        exp_is_mul[issue_tag] = is_mul;
        pending[issue_tag] = 1'b1;
        outstanding++;
        exp_tag = exp_tag + 1'b1;
        if (rd != '0) begin
            model[rd] = exp_data[issue_tag];
        end
        @(posedge clk);
        #1;
        issue.valid = 1'b0;
    endtask

    task send_instr(logic is_mul, logic [2:0] op, ooo_pkg::reg_idx_t rd,
                    ooo_pkg::reg_idx_t rs1, ooo_pkg::reg_idx_t rs2);
        wait_slot();
        drive(is_mul, op, rd, rs1, rs2, model[rs1], model[rs2]);
    endtask

    // add from r0 and r0 with the value forced onto the register file read port
    task preload_reg(ooo_pkg::reg_idx_t rd, ooo_pkg::data_t value);
        wait_slot();
        preload_val = value;
        force u_dut.rf_data1 = preload_val;
        drive(1'b0, 3'(ooo_pkg::alu_add), rd, '0, '0, value, '0);
        release u_dut.rf_data1;
    endtask

    task wait_cdb_mul(ooo_pkg::tag_t tag);
        int cycles;
        cycles = 0;
        while (!(cdb.mul.valid && cdb.mul.tag == tag)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for a multiply result on the CDB");
            end
        end
    endtask

    task drain();
        int cycles;
        cycles = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now($sformatf("%0d results never arrived on the CDB", outstanding));
            end
        end
    endtask

    task check_result(logic is_mul, ooo_pkg::fu_result_t res);
        ooo_pkg::tag_t want;
        assert (pending[res.tag])
            else fail_now($sformatf("result for tag %0d came with no instruction waiting",
                                    res.tag));
        assert (exp_is_mul[res.tag] == is_mul)
            else fail_now($sformatf("mismatch at %0t: tag %0d on the wrong CDB channel",
                                    $time, res.tag));
        assert (res.data == exp_data[res.tag])
            else fail_now($sformatf("mismatch at %0t: tag %0d data %h expected %h",
                                    $time, res.tag, res.data, exp_data[res.tag]));
        if (is_mul && mul_order.size() > 0) begin
            want = mul_order.pop_front();
            assert (res.tag == want)
                else fail_now($sformatf("mismatch at %0t: multiply tag %0d expected %0d",
                                        $time, res.tag, want));
        end
        pending[res.tag] = 1'b0;
        outstanding--;
    endtask

    // CDB is registered and stable at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (cdb.alu.valid) begin
                    check_result(1'b0, cdb.alu);
                end
                if (cdb.mul.valid) begin
                    check_result(1'b1, cdb.mul);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        issue = '0;
        outstanding = 0;
        saw_stall = 1'b0;
        preload_val = '0;
        last_tag = '0;
        exp_tag = '0;
        lcg_state = 32'd52548;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
            exp_data[t] = '0;
            exp_is_mul[t] = 1'b0;
        end
        for (int k = 0; k < `OOO_NUM_REGS; k++) begin
            model[k] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (issue_ready)
            else fail_now("issue_ready was low right after reset");

        // every alu op on preloaded sources
        preload_reg(1, 32'h1234_5678);
        preload_reg(2, 32'h0000_0007);
        preload_reg(3, 32'hfedc_ba98);
        preload_reg(4, 32'h8000_0001);
        for (int op = 0; op < 8; op++) begin
            send_instr(1'b0, 3'(op), ooo_pkg::reg_idx_t'(5 + op),
                       op[0] ? 3 : 1, op[1] ? 4 : 2);
        end
        drain();

        // back-to-back multiplies of low and high words complete in issue order
        send_instr(1'b1, 3'(ooo_pkg::mul_lo), 5, 1, 3);
        mul_order.push_back(last_tag);
        send_instr(1'b1, 3'(ooo_pkg::mul_hu), 6, 1, 3);
        mul_order.push_back(last_tag);
        send_instr(1'b1, 3'(ooo_pkg::mul_lo), 7, 3, 4);
        mul_order.push_back(last_tag);
        send_instr(1'b1, 3'(ooo_pkg::mul_hu), 8, 4, 4);
        mul_order.push_back(last_tag);
        drain();

        // snooped dependency and a younger independent op finishing first
        send_instr(1'b1, 3'(ooo_pkg::mul_lo), 9, 1, 4);
        send_instr(1'b0, 3'(ooo_pkg::alu_add), 10, 9, 2);
        send_instr(1'b0, 3'(ooo_pkg::alu_xor), 11, 1, 2);
        drain();
        // dependent op dispatched while the producer is on the CDB
        send_instr(1'b1, 3'(ooo_pkg::mul_hu), 12, 3, 3);
        wait_cdb_mul(last_tag);
        send_instr(1'b0, 3'(ooo_pkg::alu_add), 13, 12, 1);
        drain();

        // WAW on r5 around a slow multiply and writes to r0
        send_instr(1'b0, 3'(ooo_pkg::alu_add), 5, 1, 2);
        send_instr(1'b1, 3'(ooo_pkg::mul_lo), 5, 1, 3);
        send_instr(1'b0, 3'(ooo_pkg::alu_sub), 5, 3, 4);
        send_instr(1'b0, 3'(ooo_pkg::alu_add), 6, 5, 0);
        send_instr(1'b0, 3'(ooo_pkg::alu_add), 0, 1, 2);
        send_instr(1'b1, 3'(ooo_pkg::mul_lo), 0, 3, 4);
        send_instr(1'b0, 3'(ooo_pkg::alu_or), 7, 0, 0);
        drain();

        // long multiply chain fills the station
        saw_stall = 1'b0;
        for (int k = 0; k < 10; k++) begin
            send_instr(1'b1, 3'(ooo_pkg::mul_lo), 2, 2, 1);
        end
        drain();
        assert (saw_stall)
            else fail_now("issue_ready never dropped while the multiply chain was queued");

        // random mix with an occasional fresh register value
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                preload_reg(r[25:22], lcg_next());
            end else begin
                send_instr(r[31:29] <= 3'd2, r[28:26], r[25:22], r[21:18], r[17:14]);
            end
        end
        drain();

        if (outstanding == 0 && mul_order.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_now("results left unaccounted for at the end of the run");
        end
    end

endmodule

// ==== rtl/tomasulo_core.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module tomasulo_core (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::issue_req_t issue,
    output logic                issue_ready,
    output ooo_pkg::tag_t       issue_tag,
    output ooo_pkg::cdb_t       cdb
);

    logic [`OOO_RS_ENTRY_W($bits(ooo_pkg::alu_op_t))-1:0] alu_entry;
    logic [`OOO_RS_ENTRY_W($bits(ooo_pkg::mul_op_t))-1:0] mul_entry;
    logic                alu_full;
    logic                mul_full;
    ooo_pkg::fu_req_t    alu_req;
    ooo_pkg::fu_req_t    mul_req;
    ooo_pkg::fu_result_t alu_result;
    ooo_pkg::fu_result_t mul_result;
    ooo_pkg::reg_idx_t   rd_sel1;
    ooo_pkg::reg_idx_t   rd_sel2;
    ooo_pkg::data_t      rf_data1;
    ooo_pkg::data_t      rf_data2;
    ooo_pkg::reg_stat_t  stat1;
    ooo_pkg::reg_stat_t  stat2;
    logic                rename_valid;
    ooo_pkg::reg_idx_t   rename_rd;
    ooo_pkg::tag_t       rename_tag;

    dispatch_unit u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .cdb          (cdb),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .stat1        (stat1),
        .stat2        (stat2),
        .rd_sel1      (rd_sel1),
        .rd_sel2      (rd_sel2),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_tag   (rename_tag),
        .alu_entry    (alu_entry),
        .mul_entry    (mul_entry),
        .alu_full     (alu_full),
        .mul_full     (mul_full),
        .issue_ready  (issue_ready),
        .issue_tag    (issue_tag)
    );

    reservation_station #(.op_t(ooo_pkg::alu_op_t)) u_alu_rs (
        .clk      (clk),
        .rst      (rst),
        .entry_in (alu_entry),
        .cdb      (cdb),
        .full     (alu_full),
        .fu_req   (alu_req)
    );

    reservation_station #(.op_t(ooo_pkg::mul_op_t)) u_mul_rs (
        .clk      (clk),
        .rst      (rst),
        .entry_in (mul_entry),
        .cdb      (cdb),
        .full     (mul_full),
        .fu_req   (mul_req)
    );

    alu_unit u_alu (
        .clk    (clk),
        .rst    (rst),
        .req    (alu_req),
        .result (alu_result)
    );

    mul_unit u_mul (
        .clk    (clk),
        .rst    (rst),
        .req    (mul_req),
        .result (mul_result)
    );

    cdb_writeback u_writeback (
        .clk          (clk),
        .rst          (rst),
        .alu_result   (alu_result),
        .mul_result   (mul_result),
        .rd_sel1      (rd_sel1),
        .rd_sel2      (rd_sel2),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .stat1        (stat1),
        .stat2        (stat2),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_tag   (rename_tag),
        .cdb          (cdb)
    );

endmodule

// ==== rtl/cdb_writeback.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module cdb_writeback (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::fu_result_t alu_result,
    input  ooo_pkg::fu_result_t mul_result,
    input  ooo_pkg::reg_idx_t   rd_sel1,
    input  ooo_pkg::reg_idx_t   rd_sel2,
    output ooo_pkg::data_t      rf_data1,
    output ooo_pkg::data_t      rf_data2,
    output ooo_pkg::reg_stat_t  stat1,
    output ooo_pkg::reg_stat_t  stat2,
    input  logic                rename_valid,
    input  ooo_pkg::reg_idx_t   rename_rd,
    input  ooo_pkg::tag_t       rename_tag,
    output ooo_pkg::cdb_t       cdb
);

    localparam int NUM_REGS = `OOO_NUM_REGS;

    ooo_pkg::data_t     rf_q [NUM_REGS];
    ooo_pkg::reg_stat_t stat_q [NUM_REGS];

    // each unit owns a channel, no arbitration
    assign cdb.alu = alu_result;
    assign cdb.mul = mul_result;

    assign rf_data1 = rf_q[rd_sel1];
    assign rf_data2 = rf_q[rd_sel2];
    assign stat1 = stat_q[rd_sel1];
    assign stat2 = stat_q[rd_sel2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                rf_q[r] <= '0;
                stat_q[r] <= '0;
            end
        end else begin
            // r0 is skipped so it keeps its reset zero
            for (int r = 1; r < NUM_REGS; r++) begin
                if (stat_q[r].busy) begin
                    if (cdb.alu.valid && cdb.alu.tag == stat_q[r].tag) begin
                        rf_q[r] <= cdb.alu.data;
                        stat_q[r].busy <= 1'b0;
                    end else if (cdb.mul.valid && cdb.mul.tag == stat_q[r].tag) begin
                        rf_q[r] <= cdb.mul.data;
                        stat_q[r].busy <= 1'b0;
                    end
                end
                // a same-cycle rename wins over the clear
                if (rename_valid && rename_rd == ooo_pkg::reg_idx_t'(r)) begin
                    stat_q[r].busy <= 1'b1;
                    stat_q[r].tag <= rename_tag;
                end
            end
        end
    end

    // tags from dispatch are unique across both units
    distinct_cdb_tags: assert property (@(posedge clk) disable iff (rst)
        cdb.alu.valid && cdb.mul.valid |-> cdb.alu.tag != cdb.mul.tag)
        else $error("both CDB channels carry the same tag");

endmodule

// ==== rtl/mul_unit.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::fu_req_t    req,
    output ooo_pkg::fu_result_t result
);

    localparam int STAGES = `OOO_MUL_STAGES;
    localparam int XLEN = `OOO_XLEN;
    localparam int PROD_W = 2 * XLEN;

    typedef struct packed {
        logic             valid;
        ooo_pkg::mul_op_t op;
        ooo_pkg::tag_t    tag;
    } mul_ctrl_t;

    // operand stage, product stages, then word select into result
    mul_ctrl_t         ctrl_q [STAGES-1];
    ooo_pkg::data_t    a_q;
    ooo_pkg::data_t    b_q;
    logic [PROD_W-1:0] prod_q [STAGES-2];

    always_ff @(posedge clk) begin
        a_q <= req.a;
        b_q <= req.b;
        ctrl_q[0].op <= ooo_pkg::mul_op_t'(req.op[0]);
        ctrl_q[0].tag <= req.tag;
        for (int k = 1; k < STAGES - 1; k++) begin
            ctrl_q[k].op <= ctrl_q[k-1].op;
            ctrl_q[k].tag <= ctrl_q[k-1].tag;
        end

        // full unsigned product
        prod_q[0] <= PROD_W'(a_q) * PROD_W'(b_q);
        for (int k = 1; k < STAGES - 2; k++) begin
            prod_q[k] <= prod_q[k-1];
        end

        result.tag <= ctrl_q[STAGES-2].tag;
        if (ctrl_q[STAGES-2].op == ooo_pkg::mul_hu) begin
            result.data <= prod_q[STAGES-3][PROD_W-1:XLEN];
        end else begin
            result.data <= prod_q[STAGES-3][XLEN-1:0];
        end

        if (rst) begin
            for (int k = 0; k < STAGES - 1; k++) begin
                ctrl_q[k].valid <= 1'b0;
            end
            result.valid <= 1'b0;
        end else begin
            ctrl_q[0].valid <= req.valid;
            for (int k = 1; k < STAGES - 1; k++) begin
                ctrl_q[k].valid <= ctrl_q[k-1].valid;
            end
            result.valid <= ctrl_q[STAGES-2].valid;
        end
    end

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::fu_req_t    req,
    output ooo_pkg::fu_result_t result
);

    ooo_pkg::data_t alu_out;

    always_comb begin
        case (ooo_pkg::alu_op_t'(req.op))
            ooo_pkg::alu_add: alu_out = req.a + req.b;
            ooo_pkg::alu_sub: alu_out = req.a - req.b;
            ooo_pkg::alu_and: alu_out = req.a & req.b;
            ooo_pkg::alu_or:  alu_out = req.a | req.b;
            ooo_pkg::alu_xor: alu_out = req.a ^ req.b;
            // shift amount from the low five bits
            ooo_pkg::alu_sll: alu_out = req.a << req.b[4:0];
            ooo_pkg::alu_srl: alu_out = req.a >> req.b[4:0];
            ooo_pkg::alu_slt: alu_out = ooo_pkg::data_t'($signed(req.a) < $signed(req.b));
            default:          alu_out = '0;
        endcase
    end

    // one register stage, result on the CDB the cycle after the request
    always_ff @(posedge clk) begin
        result.tag <= req.tag;
        result.data <= alu_out;
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= req.valid;
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module reservation_station #(
    parameter type op_t = ooo_pkg::alu_op_t
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [`OOO_RS_ENTRY_W($bits(op_t))-1:0] entry_in,
    input  ooo_pkg::cdb_t                         cdb,
    output logic                                  full,
    output ooo_pkg::fu_req_t                      fu_req
);

    localparam int DEPTH = `OOO_RS_DEPTH;

    typedef struct packed {
        logic              valid;
        op_t               op;
        ooo_pkg::tag_t     tag;
        ooo_pkg::operand_t src1;
        ooo_pkg::operand_t src2;
    } rs_entry_t;

    rs_entry_t new_entry;
    rs_entry_t slot_q [DEPTH];
    rs_entry_t snoop [DEPTH];
    rs_entry_t shifted [DEPTH];
    rs_entry_t slot_d [DEPTH];
    logic      found;
    int        sel;
    logic      placed;

    assign new_entry = entry_in;

    // slot 0 holds the oldest entry so full means the last slot is taken
    assign full = slot_q[DEPTH-1].valid;

    // oldest entry with both operands ready goes to the unit
    always_comb begin
        found = 1'b0;
        sel = 0;
        fu_req = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && slot_q[i].valid && slot_q[i].src1.ready && slot_q[i].src2.ready) begin
                found = 1'b1;
                sel = i;
                fu_req.valid = 1'b1;
                fu_req.op = 3'(slot_q[i].op);
                fu_req.tag = slot_q[i].tag;
                fu_req.a = slot_q[i].src1.data;
                fu_req.b = slot_q[i].src2.data;
            end
        end
    end

    always_comb begin
        // snoop both CDB channels for waiting operands
        for (int i = 0; i < DEPTH; i++) begin
            snoop[i] = slot_q[i];
            snoop[i].src1 = ooo_pkg::cdb_capture(slot_q[i].src1, cdb);
            snoop[i].src2 = ooo_pkg::cdb_capture(slot_q[i].src2, cdb);
        end

        // close the gap left by the issued entry
        for (int i = 0; i < DEPTH - 1; i++) begin
            if (found && i >= sel) begin
                shifted[i] = snoop[i+1];
            end else begin
                shifted[i] = snoop[i];
            end
        end
        if (found) begin
            shifted[DEPTH-1] = '0;
        end else begin
            shifted[DEPTH-1] = snoop[DEPTH-1];
        end

        // new entry lands behind the youngest one
        slot_d = shifted;
        placed = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (new_entry.valid && !placed && !shifted[i].valid) begin
                slot_d[i] = new_entry;
                placed = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                slot_q[i].valid <= 1'b0;
            end
        end else begin
            slot_q <= slot_d;
        end
    end

    // dispatch holds off through issue_ready while any station is full
    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        new_entry.valid |-> !full)
        else $error("station written while full");

    // occupied slots stay packed toward slot 0
    for (genvar i = 0; i < DEPTH - 1; i++) begin : g_packed
        slots_compacted: assert property (@(posedge clk) disable iff (rst)
            slot_q[i+1].valid |-> slot_q[i].valid)
            else $error("station slots left a gap behind a valid entry");
    end

endmodule

// ==== rtl/dispatch_unit.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module dispatch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_pkg::issue_req_t   issue,
    input  ooo_pkg::cdb_t         cdb,
    input  ooo_pkg::data_t        rf_data1,
    input  ooo_pkg::data_t        rf_data2,
    input  ooo_pkg::reg_stat_t    stat1,
    input  ooo_pkg::reg_stat_t    stat2,
    output ooo_pkg::reg_idx_t     rd_sel1,
    output ooo_pkg::reg_idx_t     rd_sel2,
    output logic                  rename_valid,
    output ooo_pkg::reg_idx_t     rename_rd,
    output ooo_pkg::tag_t         rename_tag,
    output logic [`OOO_RS_ENTRY_W($bits(ooo_pkg::alu_op_t))-1:0] alu_entry,
    output logic [`OOO_RS_ENTRY_W($bits(ooo_pkg::mul_op_t))-1:0] mul_entry,
    input  logic                  alu_full,
    input  logic                  mul_full,
    output logic                  issue_ready,
    output ooo_pkg::tag_t         issue_tag
);

    ooo_pkg::tag_t     tag_q;
    logic              accept;
    logic              to_alu;
    logic              to_mul;
    ooo_pkg::operand_t src1;
    ooo_pkg::operand_t src2;

    // r0 and idle registers are ready with the register file value
    function automatic ooo_pkg::operand_t lookup(ooo_pkg::reg_idx_t sel,
                                                 ooo_pkg::data_t rf,
                                                 ooo_pkg::reg_stat_t st);
        ooo_pkg::operand_t opnd;
        opnd.ready = (sel == '0) || !st.busy;
        opnd.tag = st.tag;
        opnd.data = rf;
        return opnd;
    endfunction

    assign issue_ready = !alu_full && !mul_full;
    assign accept = issue.valid && issue_ready;
    assign issue_tag = tag_q;

    assign rd_sel1 = issue.rs1;
    assign rd_sel2 = issue.rs2;

    // same-cycle CDB result overrides a pending tag
    assign src1 = ooo_pkg::cdb_capture(lookup(issue.rs1, rf_data1, stat1), cdb);
    assign src2 = ooo_pkg::cdb_capture(lookup(issue.rs2, rf_data2, stat2), cdb);

    assign to_alu = accept && (issue.unit == ooo_pkg::unit_alu);
    assign to_mul = accept && (issue.unit == ooo_pkg::unit_mul);

    // field order matches the station's entry layout
    assign alu_entry = {to_alu, ooo_pkg::alu_op_t'(issue.op), tag_q, src1, src2};
    assign mul_entry = {to_mul, ooo_pkg::mul_op_t'(issue.op[0]), tag_q, src1, src2};

    // r0 is never renamed
    assign rename_valid = accept && (issue.rd != '0);
    assign rename_rd = issue.rd;
    assign rename_tag = tag_q;

    // wrapping tag counter, 16 tags outnumber the 12 possible in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q <= '0;
        end else if (accept) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    // issue_ready comes from both stations' occupancy
    issue_when_ready: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> issue_ready)
        else $error("instruction issued while a station was full");

endmodule

// ==== rtl/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

    typedef logic [`OOO_TAG_WIDTH-1:0] tag_t;
    typedef logic [`OOO_XLEN-1:0] data_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_t;

    // mul_hu returns the unsigned high word
    typedef enum logic {
        mul_lo,
        mul_hu
    } mul_op_t;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_sel_t;

    // op is read as alu_op_t or mul_op_t depending on unit
    typedef struct packed {
        logic      valid;
        unit_sel_t unit;
        logic [2:0] op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
    } issue_req_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t data;
    } operand_t;

    // register status entry, busy means a tag still owns the register
    typedef struct packed {
        logic busy;
        tag_t tag;
    } reg_stat_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] op;
        tag_t       tag;
        data_t      a;
        data_t      b;
    } fu_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } fu_result_t;

    typedef struct packed {
        fu_result_t alu;
        fu_result_t mul;
    } cdb_t;

    // a waiting operand picks up its value from either CDB channel
    function automatic operand_t cdb_capture(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            if (bus.alu.valid && bus.alu.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.data = bus.alu.data;
            end else if (bus.mul.valid && bus.mul.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.data = bus.mul.data;
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// architectural registers, r0 always reads zero
`define OOO_NUM_REGS 16

// datapath width
`define OOO_XLEN 32

// result tag width, tags handed out round robin
`define OOO_TAG_WIDTH 4

// entries per reservation station
`define OOO_RS_DEPTH 4

// multiplier latency from request to result
`define OOO_MUL_STAGES 3

// flat station entry: valid, op, dst tag, two operands
`define OOO_RS_ENTRY_W(op_w) (1 + (op_w) + `OOO_TAG_WIDTH + 2 * (1 + `OOO_TAG_WIDTH + `OOO_XLEN))

`endif
